//--- verilog/arrayMemPkg.sv
/*
  Array memory package
  Sizes, command and error codes, and the structs passed between the blocks
*/
package arrayMemPkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int ArrayBits   = 2;                  // Width of an array number
  localparam int IndexBits   = 2;                  // Width of an element index
  localparam int DataBits    = 12;                 // Element width
  localparam int Arrays      = 1 << ArrayBits;     // Number of arrays
  localparam int ArrayLength = 1 << IndexBits;     // Elements per array

  typedef logic [ArrayBits-1:0] arrayNum_t;
  typedef logic [IndexBits-1:0] index_t;
  typedef logic [DataBits-1:0]  data_t;
  typedef logic [IndexBits:0]   size_t;            // Holds 0 up to ArrayLength

  // ------------------------------
  // Commands and errors
  // ------------------------------
  typedef enum logic [3:0] {
    opClear, opAlloc, opFree,
    opWrite, opRead, opSize,
    opPush, opPop,
    opAdd, opSub, opOr, opXor, opAnd
  } memOp_t;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                               // Never handed out since Clear
    errFreed,
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory
  } memError_t;

  // ------------------------------
  // Structs
  // ------------------------------
  typedef struct packed {
    memOp_t    op;
    arrayNum_t array;
    index_t    index;
    data_t     data;
  } memRequest_t;

  typedef struct packed {
    data_t     result;
    memError_t error;
  } memResponse_t;

  typedef struct packed {
    logic      issued;                             // Handed out since Clear
    logic      allocated;
    size_t     size;
    arrayNum_t allocArray;                         // Array the next Alloc gives
    logic      canAlloc;
  } dirStatus_t;

  typedef struct packed {
    logic  clear;
    logic  alloc;
    logic  free;
    logic  setSize;
    size_t newSize;
  } dirUpdate_t;

  typedef struct packed {
    logic   enable;
    index_t index;
    data_t  data;
  } storeWrite_t;

endpackage

//--- verilog/arrayDirectory.sv
/*
  Array directory
  Tracks allocation, sizes and the freed-array stack, and reports
  the status of the addressed array
*/
`timescale 1ns/10ps

module arrayDirectory import arrayMemPkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  arrayNum_t  array,
  input  dirUpdate_t update,
  output dirStatus_t status
);

  logic      allocated [Arrays];                   // Currently allocated
  size_t     sizes [Arrays];                       // Current size of each array
  arrayNum_t freedStack [Arrays];                  // LIFO of freed array numbers
  logic [ArrayBits:0] freedTop;                    // Entries on the freed stack
  logic [ArrayBits:0] highWater;                   // Arrays issued since Clear
  arrayNum_t stackTop;
  logic      stackEmpty;

  assign stackTop   = arrayNum_t'(freedTop - 1'b1);
  assign stackEmpty = (freedTop == '0);

  // ------------------------------
  // Status of the addressed array
  // ------------------------------
  // Arrays are issued in order from 0, so the high-water count marks them
  assign status.issued     = ({1'b0, array} < highWater);
  assign status.allocated  = allocated[array];
  assign status.size       = sizes[array];
  assign status.allocArray = stackEmpty ? highWater[ArrayBits-1:0] : freedStack[stackTop];
  assign status.canAlloc   = !stackEmpty || (highWater < Arrays);

  // ------------------------------
  // Updates
  // ------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      freedTop  <= '0;
      highWater <= '0;
      for (int i = 0; i < Arrays; i++) begin
        allocated[i] <= 1'b0;
        sizes[i]     <= '0;
      end
    end else if (update.clear) begin
      freedTop  <= '0;
      highWater <= '0;
      for (int i = 0; i < Arrays; i++) begin
        allocated[i] <= 1'b0;
      end
    end else if (update.alloc) begin
      allocated[status.allocArray] <= 1'b1;
      sizes[status.allocArray]     <= '0;      // Starts empty
      if (stackEmpty) begin
        highWater <= highWater + 1'b1;           // Fresh array
      end else begin
        freedTop <= freedTop - 1'b1;             // Reuse most recently freed
      end
    end else if (update.free) begin
      allocated[array] <= 1'b0;
      freedTop         <= freedTop + 1'b1;
    end else if (update.setSize) begin
      sizes[array] <= update.newSize;
    end
  end

  // Stack contents only matter below freedTop
  always_ff @(posedge clock) begin
    if (update.free && !update.clear) begin
      freedStack[freedTop[ArrayBits-1:0]] <= array;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  // The executor only frees allocated arrays, so the stack never overflows
  stackNoOverflow: assert property (@(posedge clock) disable iff (!reset)
    update.free |-> (freedTop < Arrays) && allocated[array]);

  // Alloc is only committed when a slot is available
  stackNoUnderflow: assert property (@(posedge clock) disable iff (!reset)
    update.alloc |-> status.canAlloc);

endmodule

//--- verilog/elementStore.sv
/*
  Element store
  Holds the elements of every array, presents the addressed row
  and writes one element of that row per cycle
*/
`timescale 1ns/10ps

module elementStore import arrayMemPkg::*; (
  input  logic                    clock,
  input  arrayNum_t               array,
  output data_t [ArrayLength-1:0] row,
  input  storeWrite_t             write
);

  // ------------------------------
  // Storage
  // ------------------------------
  data_t [ArrayLength-1:0] mem [Arrays];           // One row per array

  assign row = mem[array];                         // Whole row, combinational

  always_ff @(posedge clock) begin
    if (write.enable) begin
      mem[array][write.index] <= write.data;
    end
  end

endmodule

//--- verilog/commandExecute.sv
/*
  Command executor
  Checks each request against the directory, computes the result,
  commits directory and store updates and registers the response
*/
`timescale 1ns/10ps

module commandExecute import arrayMemPkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    reqValid,
  input  memRequest_t             request,
  input  dirStatus_t              status,
  input  data_t [ArrayLength-1:0] row,
  output dirUpdate_t              dirUpdate,
  output storeWrite_t             storeWrite,
  output logic                    respValid,
  output memResponse_t            response
);

  memError_t   arrayError;                         // Access check for the addressed array
  memError_t   error;
  data_t       result;
  data_t       element;                            // Element at request index
  data_t       topElement;                         // Element at size minus one
  data_t       aluResult;
  index_t      topIndex;
  size_t       grownSize;
  size_t       shrunkSize;
  size_t       writeSize;
  logic        inRange;
  logic        commit;
  dirUpdate_t  dirNext;
  storeWrite_t writeNext;

  // ------------------------------
  // Operands
  // ------------------------------
  assign element    = row[request.index];
  assign grownSize  = status.size + 1'b1;
  assign shrunkSize = status.size - 1'b1;
  assign topIndex   = index_t'(shrunkSize);
  assign topElement = row[topIndex];
  assign writeSize  = {1'b0, request.index} + 1'b1;
  assign inRange    = ({1'b0, request.index} < status.size);

  always_comb begin
    arrayError = errNone;
    if (!status.issued) begin
      arrayError = errNotAllocated;
    end else if (!status.allocated) begin
      arrayError = errFreed;
    end
  end

  // In-place ALU, arithmetic wraps at DataBits
  always_comb begin
    case (request.op)
      opAdd:   aluResult = element + request.data;
      opSub:   aluResult = element - request.data;
      opOr:    aluResult = element | request.data;
      opXor:   aluResult = element ^ request.data;
      opAnd:   aluResult = element & request.data;
      default: aluResult = element;
    endcase
  end

  // ------------------------------
  // Decode and check
  // ------------------------------
  always_comb begin
    error           = errNone;
    result          = '0;
    dirNext         = '0;
    writeNext       = '0;
    writeNext.index = request.index;
    writeNext.data  = request.data;
    case (request.op)
      opClear: dirNext.clear = 1'b1;
      opAlloc: begin
        dirNext.alloc = 1'b1;
        result        = data_t'(status.allocArray);
        if (!status.canAlloc) error = errOutOfMemory;
      end
      opFree: begin
        error        = arrayError;
        dirNext.free = 1'b1;
      end
      opWrite: begin
        error            = arrayError;
        writeNext.enable = 1'b1;
        result           = request.data;
        dirNext.setSize  = !inRange;               // Grow to cover the index
        dirNext.newSize  = writeSize;
      end
      opRead: begin
        error  = arrayError;
        result = element;
        if (error == errNone && !inRange) error = errOutOfBounds;
      end
      opSize: begin
        error  = arrayError;
        result = data_t'(status.size);
      end
      opPush: begin
        error            = arrayError;
        writeNext.enable = 1'b1;
        writeNext.index  = status.size[IndexBits-1:0];
        dirNext.setSize  = 1'b1;
        dirNext.newSize  = grownSize;
        result           = data_t'(grownSize);
        if (error == errNone && status.size == ArrayLength) error = errFull;
      end
      opPop: begin
        error           = arrayError;
        dirNext.setSize = 1'b1;
        dirNext.newSize = shrunkSize;
        result          = topElement;
        if (error == errNone && status.size == '0) error = errEmpty;
      end
      opAdd, opSub, opOr, opXor, opAnd: begin
        error            = arrayError;
        writeNext.enable = 1'b1;
        writeNext.data   = aluResult;
        result           = aluResult;
        if (error == errNone && !inRange) error = errOutOfBounds;
      end
      default: ;                                   // Unused codes do nothing
    endcase
  end

  // ------------------------------
  // Commit and respond
  // ------------------------------
  assign commit     = reqValid && (error == errNone);
  assign dirUpdate  = commit ? dirNext : '0;
  assign storeWrite = commit ? writeNext : '0;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      respValid <= 1'b0;
    end else begin
      respValid <= reqValid;
    end
  end

  always_ff @(posedge clock) begin
    if (reqValid) begin
      response.result <= (error == errNone) ? result : '0;
      response.error  <= error;
    end
  end

  // Unallocated, out of memory, full or empty requests leave all state alone
  errorNoUpdate: assert property (@(posedge clock) disable iff (!reset)
    (reqValid && ((request.op inside {[opFree:opAnd]} && !status.allocated)
      || (request.op == opAlloc && !status.canAlloc)
      || (request.op == opPush && status.size == ArrayLength)
      || (request.op == opPop && status.size == '0)))
      |-> (dirUpdate == '0 && !storeWrite.enable));

endmodule

//--- verilog/arrayMem.sv
/*
  Array memory top level
  Joins the array directory, element store and command executor
*/
`timescale 1ns/10ps

module arrayMem import arrayMemPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         reqValid,
  input  memRequest_t  request,
  output logic         respValid,
  output memResponse_t response
);

  dirStatus_t              status;                 // Addressed array state
  dirUpdate_t              dirUpdate;
  storeWrite_t             storeWrite;
  data_t [ArrayLength-1:0] row;                    // Addressed array contents

  // ------------------------------
  // Directory and store, read side by side
  // ------------------------------
  arrayDirectory directory (
    .clock  (clock),
    .reset  (reset),
    .array  (request.array),
    .update (dirUpdate),
    .status (status)
  );

  elementStore store (
    .clock (clock),
    .array (request.array),
    .row   (row),
    .write (storeWrite)
  );

  commandExecute execute (
    .clock      (clock),
    .reset      (reset),
    .reqValid   (reqValid),
    .request    (request),
    .status     (status),
    .row        (row),
    .dirUpdate  (dirUpdate),
    .storeWrite (storeWrite),
    .respValid  (respValid),
    .response   (response)
  );

endmodule

//--- dv/arrayMemTests.svh
/*
  Array memory test sequences
  Back-to-back commands per test, each ending in a short idle
*/
`ifndef ARRAY_MEM_TESTS_SVH
`define ARRAY_MEM_TESTS_SVH

localparam int TestRequests = 5 + 16 + 13 + 26 + 14 + 7;   // Requests issued by runTests

task automatic runTests();
  memOp_t aluOps [5] = '{opAdd, opSub, opOr, opXor, opAnd};
  int     pick;
  beginTest("alloc");
  repeat (3) @(negedge clock);                     // respValid stays low while idle
  repeat (5) issue(opAlloc, 0);                    // Fifth runs out of memory
  endTest();

  beginTest("writeRead");
  for (int i = 0; i < ArrayLength; i++) begin
    issue(opRead, 0, i);                           // Index equals the size here
    issue(opWrite, 0, i, data_t'(randomBits(DataBits)));
    issue(opSize, 0);
  end
  for (int i = 0; i < ArrayLength; i++) issue(opRead, 0, i);
  endTest();

  beginTest("pushPop");
  issue(opPop, 1);                                 // Empty
  repeat (4) issue(opPush, 1, 0, data_t'(randomBits(DataBits)));
  issue(opPush, 1, 0, 12'hfff);                    // Full
  issue(opSize, 1);
  repeat (5) issue(opPop, 1);
  issue(opSize, 1);
  endTest();

  beginTest("alu");
  // Top index first, so the size jumps to 4 and later writes stay below it
  for (int i = 0; i < ArrayLength; i++) begin
    issue(opWrite, 2, ArrayLength - 1 - i, data_t'(randomBits(DataBits)));
  end
  issue(opSize, 2);
  for (int i = 0; i < 10; i++) begin
    pick = randomBits(IndexBits);
    issue(aluOps[i % 5], 2, pick, data_t'(randomBits(DataBits)));
    issue(opRead, 2, pick);
  end
  issue(opAdd, 3, 0, 12'h001);                     // Size 0 so out of bounds
  endTest();

  beginTest("freeClear");
  issue(opFree, 1);
  issue(opRead, 1, 0);
  issue(opFree, 1);                                // Already freed
  issue(opFree, 2);
  issue(opFree, 3);
  repeat (3) issue(opAlloc, 0);                    // Reuse order 3, 2, 1
  issue(opSize, 1);
  issue(opClear, 0);
  issue(opRead, 0, 0);
  issue(opWrite, 3, 1, 12'h5a5);
  repeat (2) issue(opAlloc, 0);                    // Back to 0 and 1
  endTest();

  beginTest("backToBack");
  issue(opPush, 0, 0, 12'h123);
  issue(opPop, 0);
  issue(opWrite, 0, 0, 12'h800);
  issue(opAdd, 0, 0, 12'h801);                     // Wraps past 4095
  issue(opRead, 0, 0);
  issue(opFree, 0);
  issue(opAlloc, 0);
  endTest();
endtask

`endif

//--- dv/arrayMemTb.sv
/*
  Array memory testbench
  Predicts every response with a reference model and checks it with assertions
*/
`timescale 1ns/10ps

module arrayMemTb import arrayMemPkg::*; ();

  localparam int ClockPeriod = 8;
  localparam int ResetCycles = 5;

  logic         clock = 1'b0;
  logic         reset;
  logic         reqValid;
  memRequest_t  request;
  logic         respValid;
  memResponse_t response;
  memResponse_t expected;                          // Model answer for the driven request
  memResponse_t expectedQ;                         // Lined up with respValid
  logic [31:0]  lfsr = 32'hd84dcd6b;
  string        testName = "reset";
  int           testErrors;                        // errorCount when the test began
  int           errorCount = 0;
  int           requestCount = 0;
  int           testCount = 0;

  // Reference model state
  logic         modelAllocated [Arrays] = '{default: 1'b0};
  size_t        modelSize [Arrays];
  data_t        modelData [Arrays][ArrayLength];
  arrayNum_t    freedList [$];
  int           highWater = 0;

  always #(ClockPeriod / 2) clock = ~clock;

  arrayMem UUT (.clock, .reset, .reqValid, .request, .respValid, .response);

  always @(posedge clock) expectedQ <= expected;

  // ------------------------------
  // Checks
  // ------------------------------
  responseCheck: assert property (@(posedge clock) disable iff (!reset)
    reqValid |=> respValid && response == expectedQ)
  else begin
    errorCount++;
    $display("FAIL %s expected %h/%0d actual %h/%0d", testName, $sampled(expectedQ.result),
      $sampled(expectedQ.error), $sampled(response.result), $sampled(response.error));
  end

  idleCheck: assert property (@(posedge clock) disable iff (!reset)
    !reqValid |=> !respValid)
  else begin
    errorCount++;
    $display("%s: respValid pulsed without a request", testName);
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] randomBits(int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic memResponse_t predict(memRequest_t r);
    memError_t error;
    data_t     value;
    int        a;
    a     = r.array;
    value = '0;
    error = errNone;
    if (a >= highWater) error = errNotAllocated;
    else if (!modelAllocated[a]) error = errFreed;
    case (r.op)
      opClear: begin
        error          = errNone;
        highWater      = 0;
        modelAllocated = '{default: 1'b0};
        freedList.delete();
      end
      opAlloc: begin
        error = errNone;
        if (freedList.size() > 0) value = freedList.pop_back();
        else if (highWater < Arrays) value = data_t'(highWater);
        else error = errOutOfMemory;
        if (error == errNone && value == highWater) highWater++;   // Fresh array
        if (error == errNone) modelAllocated[value] = 1'b1;
        if (error == errNone) modelSize[value] = '0;
      end
      opFree: if (error == errNone) begin
        modelAllocated[a] = 1'b0;
        freedList.push_back(r.array);
      end
      opWrite: if (error == errNone) begin
        modelData[a][r.index] = r.data;
        if (r.index >= modelSize[a]) modelSize[a] = size_t'(r.index) + 1'b1;
        value = r.data;
      end
      opSize: value = data_t'(modelSize[a]);
      opPush: begin
        if (error == errNone && modelSize[a] == ArrayLength) error = errFull;
        if (error == errNone) begin
          modelData[a][modelSize[a]] = r.data;
          modelSize[a]++;
          value = data_t'(modelSize[a]);
        end
      end
      opPop: begin
        if (error == errNone && modelSize[a] == 0) error = errEmpty;
        if (error == errNone) begin
          modelSize[a]--;
          value = modelData[a][modelSize[a]];
        end
      end
      default: begin                               // Read and the in-place ALU ops
        if (error == errNone && r.index >= modelSize[a]) error = errOutOfBounds;
        value = modelData[a][r.index];
        case (r.op)
          opAdd:  value = value + r.data;          // 12 bits wrap modulo 4096
          opSub:  value = value - r.data;
          opOr:   value = value | r.data;
          opXor:  value = value ^ r.data;
          opAnd:  value = value & r.data;
          default: ;
        endcase
        if (error == errNone && r.op != opRead) modelData[a][r.index] = value;
      end
    endcase
    if (error != errNone) value = '0;
    return '{result: value, error: error};
  endfunction

  task automatic issue(memOp_t op, int array, int index = 0, data_t data = '0);
    request  = '{op: op, array: arrayNum_t'(array), index: index_t'(index), data: data};
    reqValid = 1'b1;
    expected = predict(request);
    requestCount++;
    @(negedge clock);
    reqValid = 1'b0;
  endtask

  task automatic beginTest(string name);
    testName   = name;
    testErrors = errorCount;
  endtask

  task automatic endTest();
    repeat (2) @(negedge clock);                   // Last response gets checked
    testCount++;
    $display("%s: %0d errors", testName, errorCount - testErrors);
  endtask

  `include "arrayMemTests.svh"

  initial begin
    reset    = 1'b0;
    reqValid = 1'b0;
    request  = '0;
    expected = '0;
    repeat (ResetCycles) @(negedge clock);
    reset = 1'b1;
    runTests();
    $display("%0d tests, %0d requests, %0d errors", testCount, requestCount, errorCount);
    if (errorCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Margin covers reset and the idle cycles between tests
  initial begin
    #((ResetCycles + TestRequests + 100) * ClockPeriod);
    $display("Watchdog expired with the tests still running");
    $display("test failed");
    $finish;
  end

endmodule

//--- flist.f
+incdir+dv
verilog/arrayMemPkg.sv
verilog/arrayDirectory.sv
verilog/elementStore.sv
verilog/commandExecute.sv
verilog/arrayMem.sv
dv/arrayMemTb.sv

//--- Bender.yml
package:
  name: array_mem

sources:
  - verilog/arrayMemPkg.sv
  - verilog/arrayDirectory.sv
  - verilog/elementStore.sv
  - verilog/commandExecute.sv
  - verilog/arrayMem.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/arrayMemTb.sv
